/* bf_pkg.sv */
package bf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PIX_W      = 8;   // grey pixel.
    localparam int SIM_W      = 10;  // range similarity, full scale 1023.
    localparam int NORM_SHIFT = 10;  // a normalised weight of one reads 1024.
    localparam int WGT_W      = 21;  // raw tap weight before normalisation.
    localparam int WSUM_W     = 25;  // total of the nine raw weights.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame size and pipeline depths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int IMG_W = 8;
    localparam int IMG_H = 6;

    localparam int WIN_LAT  = 1;   // input pixel to window.
    localparam int FILT_LAT = 10;  // window to filtered pixel.

    // Gaussian spatial kernel, indexed [row][column].
    localparam logic [0:2][0:2][6:0] G_KERNEL = '{
        '{7'd109, 7'd115, 7'd109},
        '{7'd115, 7'd122, 7'd115},
        '{7'd109, 7'd115, 7'd109}
    };

    // where the window centre sits relative to the top and left borders.
    typedef enum logic [1:0] {
        EDGE_NONE   = 2'b00,
        EDGE_TOP    = 2'b10,
        EDGE_LEFT   = 2'b01,
        EDGE_CORNER = 2'b11
    } edge_e;

    // one 3x3 window with its video levels. p22 is the centre.
    typedef struct packed {
        logic             vsync;
        logic             href;
        logic             edge_flag;
        logic [PIX_W-1:0] p11;
        logic [PIX_W-1:0] p12;
        logic [PIX_W-1:0] p13;
        logic [PIX_W-1:0] p21;
        logic [PIX_W-1:0] p22;
        logic [PIX_W-1:0] p23;
        logic [PIX_W-1:0] p31;
        logic [PIX_W-1:0] p32;
        logic [PIX_W-1:0] p33;
    } win_t;

endpackage

/* range_lut.sv */
`timescale 1ns/10ps

module range_lut import bf_pkg::*; (
    input  logic [PIX_W-1:0] diff,
    output logic [SIM_W-1:0] sim
);

    logic [2:0] level;

    // one level per 32 grey steps of difference.
    assign level = diff[PIX_W-1:PIX_W-3];

    always_comb begin
        unique case (level)
            3'd0: sim = 10'd1023;
            3'd1: sim = 10'd511;
            3'd2: sim = 10'd255;
            3'd3: sim = 10'd127;
            3'd4: sim = 10'd63;
            3'd5: sim = 10'd31;
            3'd6: sim = 10'd15;
            3'd7: sim = 10'd7;   // never zero, so every tap keeps some weight.
            default: sim = '0;
        endcase
    end

endmodule

/* window_gen.sv */
`timescale 1ns/10ps

module window_gen import bf_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             vsync,
    input  logic             href,
    input  logic [PIX_W-1:0] gray,
    output win_t             win
);

    logic [$clog2(IMG_W+1)-1:0] col_cnt;
    logic [$clog2(IMG_H+1)-1:0] row_cnt;
    logic                       href_d;
    logic [$clog2(IMG_W)-1:0]   col_addr;

    logic [PIX_W-1:0]           line_buf1 [IMG_W];  // one row above the input row.
    logic [PIX_W-1:0]           line_buf2 [IMG_W];  // two rows above.
    logic [0:2][1:0][PIX_W-1:0] col_sr;             // the two previous columns per row.
    logic [0:2][PIX_W-1:0]      col_cur;
    logic [0:2]                 row_ok;
    logic [0:2]                 col_ok;
    logic [0:2][0:2][PIX_W-1:0] tap_d;
    logic [0:2][0:2][PIX_W-1:0] tap_q;
    edge_e                      edge_kind;
    logic                       vsync_q;
    logic                       href_q;
    logic                       edge_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // position counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
            href_d  <= 1'b0;
        end else begin
            href_d <= href;
            if (!vsync) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (href) begin
                col_cnt <= col_cnt + 1'b1;
            end else if (href_d) begin  // end of a line.
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    assign col_addr = col_cnt[$clog2(IMG_W)-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line buffers and column shift
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign col_cur = {line_buf2[col_addr], line_buf1[col_addr], gray};

    always_ff @(posedge clk) begin
        if (href) begin
            line_buf1[col_addr] <= gray;
            line_buf2[col_addr] <= line_buf1[col_addr];
            for (int i = 0; i < 3; i++) begin
                col_sr[i] <= {col_sr[i][0], col_cur[i]};
            end
        end
    end

    // taps above row 0 or left of column 0 hold stale data and read as zero.
    assign row_ok = {row_cnt >= 2, row_cnt >= 1, 1'b1};
    assign col_ok = {col_cnt >= 2, col_cnt >= 1, 1'b1};

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tap_d[i][0] = (row_ok[i] && col_ok[0]) ? col_sr[i][1] : '0;
            tap_d[i][1] = (row_ok[i] && col_ok[1]) ? col_sr[i][0] : '0;
            tap_d[i][2] = (row_ok[i] && col_ok[2]) ? col_cur[i] : '0;
        end
    end

    // the centre lags the input by one row and one column.
    always_comb begin
        if (row_cnt <= 1 && col_cnt <= 1) begin
            edge_kind = EDGE_CORNER;
        end else if (row_cnt <= 1) begin
            edge_kind = EDGE_TOP;
        end else if (col_cnt <= 1) begin
            edge_kind = EDGE_LEFT;
        end else begin
            edge_kind = EDGE_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_q <= 1'b0;
            href_q  <= 1'b0;
            edge_q  <= 1'b0;
        end else begin
            vsync_q <= vsync;
            href_q  <= href;
            edge_q  <= (edge_kind != EDGE_NONE);
        end
    end

    always_ff @(posedge clk) begin
        tap_q <= tap_d;
    end

    assign win = '{vsync: vsync_q, href: href_q, edge_flag: edge_q,
                   p11: tap_q[0][0], p12: tap_q[0][1], p13: tap_q[0][2],
                   p21: tap_q[1][0], p22: tap_q[1][1], p23: tap_q[1][2],
                   p31: tap_q[2][0], p32: tap_q[2][1], p33: tap_q[2][2]};

    a_col_in_line: assert property (@(posedge clk) disable iff (!rst_n)
        href |-> col_cnt < IMG_W)
        else $error("window_gen: line longer than IMG_W pixels.");

endmodule

/* bilateral_weights.sv */
`timescale 1ns/10ps

module bilateral_weights import bf_pkg::*; (
    input  logic                  clk,
    input  win_t                  win,
    output logic [0:8][SIM_W-1:0] norm_w
);

    logic [0:8][PIX_W-1:0]           px;
    wire  [0:8][SIM_W-1:0]           sim;
    logic [0:2][0:2][0:2][WGT_W-1:0] prod_q;     // [row][column][term].
    logic [0:2][0:2][WGT_W-1:0]      wgt_q;
    logic [0:2][0:2][WGT_W-1:0]      wgt_d1;
    logic [0:2][0:2][WGT_W-1:0]      wgt_d2;
    logic [0:2][WSUM_W-1:0]          row_sum_q;
    logic [WSUM_W-1:0]               wsum_q;

    assign px = {win.p11, win.p12, win.p13,
                 win.p21, win.p22, win.p23,
                 win.p31, win.p32, win.p33};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1: distance of each neighbour from the centre, then similarity
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar k = 0; k < 9; k++) begin : g_tap
        if (k == 4) begin : g_centre
            assign sim[k] = {SIM_W{1'b1}};  // zero difference, full similarity.
        end else begin : g_nbr
            logic [PIX_W-1:0] diff_q;

            always_ff @(posedge clk) begin
                diff_q <= (px[k] > px[4]) ? px[k] - px[4] : px[4] - px[k];
            end

            range_lut i_range_lut (
                .diff (diff_q),
                .sim  (sim[k])
            );
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stages 2 and 3: similarity matrix times the spatial kernel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Weight (i,j) is row i of the similarities dotted with kernel column j.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                for (int k = 0; k < 3; k++) begin
                    prod_q[i][j][k] <= WGT_W'(sim[3*i+k]) * WGT_W'(G_KERNEL[k][j]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                wgt_q[i][j] <= prod_q[i][j][0] + prod_q[i][j][1] + prod_q[i][j][2];
            end
        end
    end

    // stages 4 and 5 build the total while the tap weights wait.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            row_sum_q[i] <= WSUM_W'(wgt_q[i][0]) + WSUM_W'(wgt_q[i][1]) +
                            WSUM_W'(wgt_q[i][2]);
        end
        wsum_q <= row_sum_q[0] + row_sum_q[1] + row_sum_q[2];
        wgt_d1 <= wgt_q;
        wgt_d2 <= wgt_d1;
    end

    // stage 6. The centre term keeps the total above zero, and each quotient
    // stays below 1024 because every neighbour weight is positive.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                norm_w[3*i+j] <= SIM_W'({wgt_d2[i][j], {NORM_SHIFT{1'b0}}} / wsum_q);
            end
        end
    end

endmodule

/* weighted_blend.sv */
`timescale 1ns/10ps

module weighted_blend import bf_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  win_t                  win,
    input  logic [0:8][SIM_W-1:0] norm_w,
    output logic                  post_vsync,
    output logic                  post_href,
    output logic [PIX_W-1:0]      post_gray
);

    logic [0:8][PIX_W-1:0]       px;
    logic [0:8][PIX_W-1:0]       px_dly [6];   // matches the six-stage weight pipeline.
    logic [PIX_W-1:0]            ctr_dly [3];
    logic [0:8][PIX_W+SIM_W-1:0] prod_q;
    logic [0:2][PIX_W+SIM_W-1:0] col_sum_q;
    logic [PIX_W+SIM_W-1:0]      total_q;
    logic [FILT_LAT-1:0]         vsync_sr;
    logic [FILT_LAT-1:0]         href_sr;
    logic [FILT_LAT-2:0]         edge_sr;

    assign px = {win.p11, win.p12, win.p13,
                 win.p21, win.p22, win.p23,
                 win.p31, win.p32, win.p33};

    always_ff @(posedge clk) begin
        px_dly[0] <= px;
        for (int n = 1; n < 6; n++) begin
            px_dly[n] <= px_dly[n-1];
        end
        ctr_dly[0] <= px_dly[5][4];
        ctr_dly[1] <= ctr_dly[0];
        ctr_dly[2] <= ctr_dly[1];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // weighted sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The weights add up to at most 1024, so the total fits 18 bits.
    always_ff @(posedge clk) begin
        for (int k = 0; k < 9; k++) begin
            prod_q[k] <= px_dly[5][k] * norm_w[k];
        end
        for (int j = 0; j < 3; j++) begin
            col_sum_q[j] <= prod_q[j] + prod_q[3+j] + prod_q[6+j];
        end
        total_q <= col_sum_q[0] + col_sum_q[1] + col_sum_q[2];
    end

    // border centres pass through, the rest round to nearest.
    always_ff @(posedge clk) begin
        if (edge_sr[FILT_LAT-2]) begin
            post_gray <= ctr_dly[2];
        end else begin
            post_gray <= total_q[NORM_SHIFT+PIX_W-1:NORM_SHIFT] + total_q[NORM_SHIFT-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_sr <= '0;
            href_sr  <= '0;
            edge_sr  <= '0;
        end else begin
            vsync_sr <= {vsync_sr[FILT_LAT-2:0], win.vsync};
            href_sr  <= {href_sr[FILT_LAT-2:0], win.href};
            edge_sr  <= {edge_sr[FILT_LAT-3:0], win.edge_flag};
        end
    end

    assign post_vsync = vsync_sr[FILT_LAT-1];
    assign post_href  = href_sr[FILT_LAT-1];

    a_href_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(post_href) |-> post_vsync)
        else $error("weighted_blend: line starts outside a frame.");

endmodule

/* bilateral_filter.sv */
`timescale 1ns/10ps

module bilateral_filter import bf_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             vsync,
    input  logic             href,
    input  logic [PIX_W-1:0] gray,
    output logic             post_vsync,
    output logic             post_href,
    output logic [PIX_W-1:0] post_gray
);

    win_t                  win;
    logic [0:8][SIM_W-1:0] norm_w;

    // one cycle to the window, ten more through weights and blend.
    window_gen i_window_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .vsync (vsync),
        .href  (href),
        .gray  (gray),
        .win   (win)
    );

    bilateral_weights i_bilateral_weights (
        .clk    (clk),
        .win    (win),
        .norm_w (norm_w)
    );

    weighted_blend i_weighted_blend (
        .clk        (clk),
        .rst_n      (rst_n),
        .win        (win),
        .norm_w     (norm_w),
        .post_vsync (post_vsync),
        .post_href  (post_href),
        .post_gray  (post_gray)
    );

endmodule

/* tb_bilateral_filter.sv */
`timescale 1ns/10ps

module tb_bilateral_filter import bf_pkg::*; ();

    localparam int NUM_PIX      = IMG_W * IMG_H;
    localparam int LINE_GAP     = 4;   // idle cycles after each line.
    localparam int LEAD         = 2;   // vsync high before the first line.
    localparam int PIPE_LAT     = 11;  // input pixel to filtered pixel.
    localparam int FRAME_CYC    = LEAD + IMG_H * (IMG_W + LINE_GAP);
    localparam int WATCHDOG_CYC = 3 * FRAME_CYC + 100;

    logic                clk;
    logic                rst_n;
    logic                vsync;
    logic                href;
    logic [PIX_W-1:0]    gray;
    logic                post_vsync;
    logic                post_href;
    logic [PIX_W-1:0]    post_gray;

    logic [PIX_W-1:0]    vec [2*NUM_PIX];  // input and expected output per pixel.
    int                  exp_q[$];
    int                  bound_q[$];
    logic [PIPE_LAT-1:0] vsync_hist;
    logic [PIPE_LAT-1:0] href_hist;
    int                  out_count;
    int unsigned         lcg_state;

    bilateral_filter i_bilateral_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .vsync      (vsync),
        .href       (href),
        .gray       (gray),
        .post_vsync (post_vsync),
        .post_href  (post_href),
        .post_gray  (post_gray)
    );

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic end_with_failure();
        $display("Done: errors found");
        $fatal(1, "run stopped at the first failure.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            end_with_failure();
        end
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // largest tap of the window that input pixel (r,c) completes, or -1 at a border.
    function automatic int window_max(input int r, input int c);
        int best;
        int v;
        best = -1;
        if (r >= 2 && c >= 2) begin
            for (int dr = -2; dr <= 0; dr++) begin
                for (int dc = -2; dc <= 0; dc++) begin
                    v = vec[2*((r+dr)*IMG_W + c + dc)];
                    if (v > best) begin
                        best = v;
                    end
                end
            end
        end
        return best;
    endfunction

    // one frame of href bursts, entered and left on a rising edge.
    task automatic send_frame();
        int idx;
        vsync <= 1'b1;
        href  <= 1'b0;
        gray  <= '0;
        repeat (LEAD) @(posedge clk);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                idx = r * IMG_W + c;
                href <= 1'b1;
                gray <= vec[2*idx];
                exp_q.push_back(vec[2*idx+1]);
                bound_q.push_back(window_max(r, c));
                @(posedge clk);
            end
            href <= 1'b0;
            gray <= '0;
            repeat (LINE_GAP) @(posedge clk);
        end
        vsync <= 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitor, sampled on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : monitor
        int expected;
        int bound;
        check_value("post_vsync", post_vsync, vsync_hist[PIPE_LAT-1]);
        check_value("post_href", post_href, href_hist[PIPE_LAT-1]);
        vsync_hist = {vsync_hist[PIPE_LAT-2:0], vsync};
        href_hist  = {href_hist[PIPE_LAT-2:0], href};
        if (post_href) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: post_href is high but no pixel is pending.", $time);
                end_with_failure();
            end else begin
                expected = exp_q.pop_front();
                bound    = bound_q.pop_front();
                check_value("post_gray", post_gray, expected);
                if (bound >= 0 && post_gray > bound) begin
                    $display("Error at %0t: post_gray %0d is above the largest tap %0d.",
                             $time, post_gray, bound);
                    end_with_failure();
                end
                out_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Error: the filtered frames did not finish within %0d cycles.",
                 WATCHDOG_CYC);
        end_with_failure();
    end

    initial begin
        int gap;
        $timeformat(-9, 1, " ns", 0);
        clk        = 1'b0;
        rst_n      = 1'b0;
        vsync      = 1'b0;
        href       = 1'b0;
        gray       = '0;
        vsync_hist = '0;
        href_hist  = '0;
        out_count  = 0;
        lcg_state  = 32'd81478;
        $readmemh("bilateral_filter_vectors.txt", vec);
        if ($isunknown(vec[2*NUM_PIX-1])) begin
            $display("Error: the vector file is missing or has fewer than %0d pixels.",
                     NUM_PIX);
            end_with_failure();
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("post_vsync", post_vsync, 0);
        check_value("post_href", post_href, 0);

        @(posedge clk);
        send_frame();
        gap = 4 + int'(lcg_next() % 8);  // vsync stays low for 4 to 11 cycles.
        repeat (gap) @(posedge clk);
        send_frame();

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (PIPE_LAT + 2) @(posedge clk);

        if (out_count == 2 * NUM_PIX) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Error: %0d filtered pixels came out where %0d were sent.",
                     out_count, 2 * NUM_PIX);
            end_with_failure();
        end
    end

endmodule

/* bilateral_filter_vectors.txt */
// each line holds the input gray value and then the expected post_gray, in hex.
// one 8x6 frame in raster order with a step from 28 to c8 between rows 2 and 3.
28 00
28 00
28 00
28 00
28 00
28 00
28 00
28 00
28 00
28 28
28 28
28 28
28 28
28 28
28 28
28 28
28 00
28 28
28 28
28 28
28 28
28 28
28 28
28 28
c8 00
c8 28
c8 2a
c8 2a
c8 2a
c8 2a
c8 2a
c8 2a
c8 00
c8 c8
c8 c5
c8 c5
c8 c5
c8 c5
c8 c5
c8 c5
c8 00
c8 c8
c8 c7
c8 c7
c8 c7
c8 c7
c8 c7
c8 c7

/* files.f */
bf_pkg.sv
range_lut.sv
window_gen.sv
bilateral_weights.sv
weighted_blend.sv
bilateral_filter.sv
tb_bilateral_filter.sv

/* Bender.yml */
package:
  name: bilateral_filter

sources:
  - bf_pkg.sv
  - range_lut.sv
  - window_gen.sv
  - bilateral_weights.sv
  - weighted_blend.sv
  - bilateral_filter.sv
  - target: simulation
    files:
      - tb_bilateral_filter.sv
